//--- Bender.yml
package:
  name: board_init

sources:
  - files:
      - board_init_pkg.sv
      - reset_step.sv
      - reset_chain.sv
      - eeprom_capture.sv
      - mac_ip_select.sv
      - board_init_top.sv
  - target: test
    files:
      - board_init_assert.sv
      - tb_board_init.sv

//--- board_init_assert.sv
module board_init_assert #(
	parameter int NSTEP = 6,
	parameter int RESET_LEN = 10
) (
	input logic hw,
	input logic poweronreset,
	input logic [NSTEP-1:0] done_criteria,
	input logic [NSTEP-1:0] step_reset,
	input logic [NSTEP-1:0] step_done,
	input logic [NSTEP-1:0] step_error
);

	int unsigned fail_count = 0; // failed assertions so far

	genvar k;
	generate
		for (k = 0; k < NSTEP; k++) begin : gen_check
			// fixed reset pulse length
			reset_len: assert property (@(posedge hw) disable iff (poweronreset)
				$rose(step_reset[k]) |-> step_reset[k] [*RESET_LEN] ##1 !step_reset[k])
				else begin
					$error("step %0d reset pulse is not %0d cycles long", k, RESET_LEN);
					fail_count++;
				end

			// done needs the criterion
			done_on_criterion: assert property (@(posedge hw) disable iff (poweronreset)
				$rose(step_done[k]) |-> $past(done_criteria[k]))
				else begin
					$error("step %0d done without its criterion", k);
					fail_count++;
				end

			// error only while the criterion is low
			error_on_timeout: assert property (@(posedge hw) disable iff (poweronreset)
				$rose(step_error[k]) |-> !$past(done_criteria[k]))
				else begin
					$error("step %0d error while its criterion was high", k);
					fail_count++;
				end

			if (k > 0) begin : gen_order
				in_order: assert property (@(posedge hw) disable iff (poweronreset)
					$rose(step_reset[k]) |-> step_done[k-1])
					else begin
						$error("step %0d reset rose before step %0d was done", k, k - 1);
						fail_count++;
					end
			end
		end
	endgenerate

endmodule

bind reset_chain board_init_assert #(
	.NSTEP(NSTEP),
	.RESET_LEN(RESET_LEN)
) i_board_init_assert (
	.hw(hw),
	.poweronreset(poweronreset),
	.done_criteria(done_criteria),
	.step_reset(step_reset),
	.step_done(step_done),
	.step_error(step_error)
);

//--- board_init_pkg.sv
package board_init_pkg;

	// cycle counts for ready and reset lengths
	typedef logic [15:0] cycle_count_t;
	typedef logic [31:0] timeout_count_t;

	// i2c stream words
	typedef logic [31:0] i2c_data_t;
	typedef logic [36:0] i2c_cmd_t; // stop bit, 4 nack bits, payload

	// board identity
	typedef logic [47:0] mac_t;
	typedef logic [31:0] ip_t;
	typedef logic [79:0] eeprom_id_t; // mac in the top 48 bits

	// one reset step
	typedef enum logic [2:0] {
		st_idle,
		st_wait_ready,
		st_in_reset,
		st_wait_done,
		st_done,
		st_error
	} step_state_t;

	// mux select command is stop=1, nack=2, payload e8 ll 00 00
	localparam logic [7:0] mux_select_byte = 8'he8;
	localparam logic [3:0] mux_select_nack = 4'h2;

	// mux port of the identity eeprom
	localparam logic [7:0] eeprom_location = 8'd8;

	// payload bit that marks a read
	localparam int read_bit_index = 24;

	// factory identity
	localparam mac_t default_mac = 48'h503eaa059701;
	localparam ip_t default_ip = 32'hc0a801e0; // 192.168.1.224

endpackage

//--- board_init_top.sv
module board_init_top #(
	parameter int NSTEP = 6,
	parameter int READY_LEN = 10,
	parameter int RESET_LEN = 10,
	parameter int TIMEOUT = 200, // 0 disables the done timeout
	parameter int LOAD_STEP = 3
) (
	input logic hw,
	input logic poweronreset,
	input logic hwreset_req,
	input logic [NSTEP-1:0] done_criteria,
	input board_init_pkg::i2c_cmd_t i2c_cmd,
	input logic i2c_result_valid,
	input board_init_pkg::i2c_data_t i2c_result_data,
	input logic i2c_init_done,
	input logic use_default_id,
	output logic [NSTEP-1:0] step_reset,
	output logic [NSTEP-1:0] step_done,
	output logic [NSTEP-1:0] step_error,
	output board_init_pkg::mac_t mac,
	output board_init_pkg::ip_t ip
);
	import board_init_pkg::*;

	logic poweronreset_d; // delayed copy for the falling edge
	logic chain_start;
	eeprom_id_t eeprom_id;

	always_ff @(posedge hw) begin
		poweronreset_d <= poweronreset;
	end

	// first cycle out of power-on reset, or a hardware reset request
	assign chain_start = (poweronreset_d && !poweronreset) || hwreset_req;

	reset_chain #(
		.NSTEP(NSTEP),
		.READY_LEN(READY_LEN),
		.RESET_LEN(RESET_LEN),
		.TIMEOUT(TIMEOUT)
	) i_reset_chain (
		.hw(hw),
		.poweronreset(poweronreset),
		.start(chain_start),
		.done_criteria(done_criteria),
		.step_reset(step_reset),
		.step_done(step_done),
		.step_error(step_error)
	);

	eeprom_capture i_eeprom_capture (
		.hw(hw),
		.poweronreset(poweronreset),
		.i2c_cmd(i2c_cmd),
		.i2c_result_valid(i2c_result_valid),
		.i2c_result_data(i2c_result_data),
		.i2c_init_done(i2c_init_done),
		.eeprom_id(eeprom_id)
	);

	// identity is loaded by the reset of the load step
	mac_ip_select i_mac_ip_select (
		.hw(hw),
		.poweronreset(poweronreset),
		.load(step_reset[LOAD_STEP]),
		.use_default_id(use_default_id),
		.eeprom_id(eeprom_id),
		.mac(mac),
		.ip(ip)
	);

endmodule

//--- eeprom_capture.sv
module eeprom_capture (
	input logic hw,
	input logic poweronreset,
	input board_init_pkg::i2c_cmd_t i2c_cmd,
	input logic i2c_result_valid,
	input board_init_pkg::i2c_data_t i2c_result_data,
	input logic i2c_init_done,
	output board_init_pkg::eeprom_id_t eeprom_id
);
	import board_init_pkg::*;

	i2c_data_t payload;
	logic stop_bit;
	logic [3:0] nack;
	logic mux_select;
	logic [7:0] location; // current i2c mux port
	logic result_valid_d;
	logic result_rise;
	logic capture;

	assign stop_bit = i2c_cmd[36];
	assign nack = i2c_cmd[35:32];
	assign payload = i2c_cmd[31:0];

	// only the location byte may vary in a mux select command
	assign mux_select = stop_bit
		&& (nack == mux_select_nack)
		&& (payload[31:24] == mux_select_byte)
		&& (payload[15:0] == 16'h0);

	always_ff @(posedge hw) begin
		if (poweronreset) begin
			location <= '0;
		end else if (mux_select) begin
			location <= payload[23:16];
		end
	end

	// each result shows up as a new rising edge of valid
	always_ff @(posedge hw) begin
		if (poweronreset) begin
			result_valid_d <= 1'b0;
		end else begin
			result_valid_d <= i2c_result_valid;
		end
	end

	assign result_rise = i2c_result_valid && !result_valid_d;

	// eeprom reads during init only
	assign capture = result_rise
		&& (location == eeprom_location)
		&& payload[read_bit_index]
		&& !i2c_init_done;

	// oldest byte ends up in the mac top byte
	always_ff @(posedge hw) begin
		if (poweronreset) begin
			eeprom_id <= '0;
		end else if (capture) begin
			eeprom_id <= {eeprom_id[71:0], i2c_result_data[7:0]};
		end
	end

endmodule

//--- mac_ip_select.sv
module mac_ip_select (
	input logic hw,
	input logic poweronreset,
	input logic load,
	input logic use_default_id,
	input board_init_pkg::eeprom_id_t eeprom_id,
	output board_init_pkg::mac_t mac,
	output board_init_pkg::ip_t ip
);
	import board_init_pkg::*;

	logic load_d;
	logic load_rise;
	mac_t next_mac;
	ip_t next_ip;

	always_ff @(posedge hw) begin
		if (poweronreset) begin
			load_d <= 1'b0;
		end else begin
			load_d <= load;
		end
	end

	assign load_rise = load && !load_d; // once per load step reset

	// switch picks the factory identity over the eeprom
	always_comb begin
		if (use_default_id) begin
			next_mac = default_mac;
			next_ip = default_ip;
		end else begin
			next_mac = eeprom_id[79:32];
			next_ip = eeprom_id[31:0];
		end
	end

	always_ff @(posedge hw) begin
		if (poweronreset) begin
			mac <= default_mac;
			ip <= default_ip;
		end else if (load_rise) begin
			mac <= next_mac;
			ip <= next_ip;
		end
	end

endmodule

//--- reset_chain.sv
module reset_chain #(
	parameter int NSTEP = 6,
	parameter int READY_LEN = 10,
	parameter int RESET_LEN = 10,
	parameter int TIMEOUT = 200
) (
	input logic hw,
	input logic poweronreset,
	input logic start,
	input logic [NSTEP-1:0] done_criteria,
	output logic [NSTEP-1:0] step_reset,
	output logic [NSTEP-1:0] step_done,
	output logic [NSTEP-1:0] step_error
);
	logic [NSTEP-1:0] done_strobe;
	logic [NSTEP-1:0] step_start;
	logic [NSTEP-1:0] step_ready;

	// each step is started by the done strobe of the one before
	assign step_start = {done_strobe[NSTEP-2:0], start};

	// step 0 is always ready, the others wait on the previous criterion
	assign step_ready = {done_criteria[NSTEP-2:0], 1'b1};

	genvar k;
	generate
		for (k = 0; k < NSTEP; k++) begin : gen_step
			reset_step #(
				.READY_LEN(READY_LEN),
				.RESET_LEN(RESET_LEN),
				.TIMEOUT(TIMEOUT)
			) i_reset_step (
				.hw(hw),
				.poweronreset(poweronreset),
				.start(step_start[k]),
				.ready(step_ready[k]),
				.done_criterion(done_criteria[k]),
				.reset_out(step_reset[k]),
				.done(step_done[k]),
				.done_strobe(done_strobe[k]),
				.error(step_error[k])
			);
		end
	endgenerate

endmodule

//--- reset_step.sv
module reset_step #(
	parameter int READY_LEN = 10,
	parameter int RESET_LEN = 10,
	parameter int TIMEOUT = 200
) (
	input logic hw,
	input logic poweronreset,
	input logic start,
	input logic ready,
	input logic done_criterion,
	output logic reset_out,
	output logic done,
	output logic done_strobe,
	output logic error
);
	import board_init_pkg::*;

	step_state_t state;
	cycle_count_t cnt; // ready run, then reset pulse length
	timeout_count_t wait_cnt; // cycles spent in wait_done
	logic last_ready;
	logic last_reset;
	logic timed_out;

	// readiness seen for the READY_LEN-th cycle in a row
	assign last_ready = ready && (cnt == cycle_count_t'(READY_LEN - 1));
	assign last_reset = (cnt == cycle_count_t'(RESET_LEN - 1));
	// TIMEOUT of 0 never expires
	assign timed_out = (TIMEOUT != 0) && (wait_cnt == timeout_count_t'(TIMEOUT - 1));

	always_ff @(posedge hw) begin
		if (poweronreset) begin
			state <= st_idle;
			cnt <= '0;
			wait_cnt <= '0;
			done_strobe <= 1'b0;
		end else begin
			done_strobe <= 1'b0;
			if (start) begin
				// restart from any state
				state <= st_wait_ready;
				cnt <= '0;
				wait_cnt <= '0;
			end else begin
				case (state)
					st_wait_ready: begin
						if (!ready) begin
							cnt <= '0; // run broken
						end else if (last_ready) begin
							state <= st_in_reset;
							cnt <= '0;
						end else begin
							cnt <= cnt + 1'b1;
						end
					end
					st_in_reset: begin
						if (last_reset) begin
							state <= st_wait_done;
							cnt <= '0;
							wait_cnt <= '0;
						end else begin
							cnt <= cnt + 1'b1;
						end
					end
					st_wait_done: begin
						if (done_criterion) begin
							state <= st_done;
							done_strobe <= 1'b1; // kicks the next step
						end else if (timed_out) begin
							state <= st_error;
						end else begin
							wait_cnt <= wait_cnt + 1'b1;
						end
					end
					st_idle, st_done, st_error: begin
						state <= state; // hold until the next start
					end
					default: begin
						state <= st_idle;
					end
				endcase
			end
		end
	end

	assign reset_out = (state == st_in_reset);
	assign done = (state == st_done);
	assign error = (state == st_error);

endmodule

//--- src.f
board_init_pkg.sv
reset_step.sv
reset_chain.sv
eeprom_capture.sv
mac_ip_select.sv
board_init_top.sv
board_init_assert.sv
tb_board_init.sv

//--- tb_board_init.sv
module tb_board_init;

	localparam int NSTEP = 6;
	localparam int READY_LEN = 10;
	localparam int RESET_LEN = 10;
	localparam int TIMEOUT = 200;
	localparam int LOAD_STEP = 3;
	localparam int NRUN = 6; // chain runs over all tests
	localparam int RUN_CAP = 2 * NSTEP * (READY_LEN + RESET_LEN + TIMEOUT);
	localparam int WATCHDOG_CYCLES = NSTEP * (READY_LEN + RESET_LEN + TIMEOUT) * NRUN + 2000;
	localparam logic [47:0] FACTORY_MAC = 48'h503eaa059701;
	localparam logic [31:0] FACTORY_IP = 32'hc0a801e0;

	// model step states
	localparam int S_IDLE = 0;
	localparam int S_READY = 1;
	localparam int S_RESET = 2;
	localparam int S_WAIT = 3;
	localparam int S_DONE = 4;
	localparam int S_ERROR = 5;

	logic hw;
	logic poweronreset;
	logic hwreset_req;
	logic [NSTEP-1:0] done_criteria;
	logic [36:0] i2c_cmd;
	logic i2c_result_valid;
	logic [31:0] i2c_result_data;
	logic i2c_init_done;
	logic use_default_id;
	logic [NSTEP-1:0] step_reset;
	logic [NSTEP-1:0] step_done;
	logic [NSTEP-1:0] step_error;
	logic [47:0] mac;
	logic [31:0] ip;

	int m_state [NSTEP];
	int m_cnt [NSTEP];
	int delay [NSTEP]; // cycles before a criterion is raised
	logic [NSTEP-1:0] m_strobe;
	logic [NSTEP-1:0] m_fresh; // step started by the current wave
	logic m_por_d = 1'b0;
	logic m_valid_d;
	logic m_load_d;
	logic [7:0] m_loc;
	logic [79:0] m_id;
	logic [47:0] m_mac;
	logic [31:0] m_ip;
	bit checks_on = 0;
	int errors = 0;
	int checks = 0;
	int passed = 0;
	int failed = 0;

	board_init_top i_board_init_top (
		.hw(hw),
		.poweronreset(poweronreset),
		.hwreset_req(hwreset_req),
		.done_criteria(done_criteria),
		.i2c_cmd(i2c_cmd),
		.i2c_result_valid(i2c_result_valid),
		.i2c_result_data(i2c_result_data),
		.i2c_init_done(i2c_init_done),
		.use_default_id(use_default_id),
		.step_reset(step_reset),
		.step_done(step_done),
		.step_error(step_error),
		.mac(mac),
		.ip(ip)
	);

	initial begin
		hw = 1'b0;
		forever #50 hw = ~hw;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge hw);
		$display("watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
		$display("=== FAIL ===");
		$finish;
	end

	// cycle model of the chain and the identity path
	always @(posedge hw) begin : ref_model
		logic [NSTEP-1:0] strobe_q;
		logic load_q;
		logic go;
		logic rdy;
		strobe_q = m_strobe;
		load_q = (m_state[LOAD_STEP] == S_RESET);
		if (poweronreset) begin
			for (int k = 0; k < NSTEP; k++) begin
				m_state[k] = S_IDLE;
				m_cnt[k] = 0;
			end
			m_strobe = '0;
			m_fresh = '0;
			m_valid_d = 1'b0;
			m_load_d = 1'b0;
			m_loc = '0;
			m_id = '0;
			m_mac = FACTORY_MAC;
			m_ip = FACTORY_IP;
		end else begin
			m_strobe = '0;
			for (int k = 0; k < NSTEP; k++) begin
				go = (k == 0) ? ((m_por_d && !poweronreset) || hwreset_req) : strobe_q[k-1];
				rdy = (k == 0) ? 1'b1 : done_criteria[k-1];
				if (go) begin
					m_state[k] = S_READY;
					m_cnt[k] = 0;
					m_fresh[k] = 1'b1;
				end else if (m_state[k] == S_READY) begin
					m_cnt[k] = rdy ? m_cnt[k] + 1 : 0; // consecutive ready cycles
					if (m_cnt[k] == READY_LEN) begin
						m_state[k] = S_RESET;
						m_cnt[k] = 0;
					end
				end else if (m_state[k] == S_RESET) begin
					m_cnt[k]++;
					if (m_cnt[k] == RESET_LEN) begin
						m_state[k] = S_WAIT;
						m_cnt[k] = 0;
					end
				end else if (m_state[k] == S_WAIT) begin
					if (done_criteria[k]) begin
						m_state[k] = S_DONE;
						m_strobe[k] = 1'b1;
					end else begin
						m_cnt[k]++;
						if (TIMEOUT != 0 && m_cnt[k] == TIMEOUT)
							m_state[k] = S_ERROR;
					end
				end
			end
			if (load_q && !m_load_d) begin // identity taken from the old capture
				m_mac = use_default_id ? FACTORY_MAC : m_id[79:32];
				m_ip = use_default_id ? FACTORY_IP : m_id[31:0];
			end
			m_load_d = load_q;
			if (i2c_result_valid && !m_valid_d && m_loc == 8'd8 && i2c_cmd[24] && !i2c_init_done)
				m_id = {m_id[71:0], i2c_result_data[7:0]};
			m_valid_d = i2c_result_valid;
			if (i2c_cmd[36:24] == {1'b1, 4'h2, 8'he8} && i2c_cmd[15:0] == 16'h0)
				m_loc = i2c_cmd[23:16];
		end
		m_por_d = poweronreset;
	end

	task automatic compare(input string name, input logic [79:0] actual, input logic [79:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("MISMATCH at %0t: %s got %h expected %h", $time, name, actual, expected);
		end
	endtask

	always @(negedge hw) begin : check_outputs
		logic [NSTEP-1:0] exp_reset;
		logic [NSTEP-1:0] exp_done;
		logic [NSTEP-1:0] exp_error;
		if (checks_on) begin
			for (int k = 0; k < NSTEP; k++) begin
				exp_reset[k] = (m_state[k] == S_RESET);
				exp_done[k] = (m_state[k] == S_DONE);
				exp_error[k] = (m_state[k] == S_ERROR);
			end
			compare("step_reset", step_reset, exp_reset);
			compare("step_done", step_done, exp_done);
			compare("step_error", step_error, exp_error);
			compare("mac", mac, m_mac);
			compare("ip", ip, m_ip);
		end
	end

	task automatic pick_delays();
		for (int k = 0; k < NSTEP; k++)
			delay[k] = $urandom_range(0, 20);
	endtask

	// drops all criteria and raises the request, lowered at the next falling edge
	task automatic begin_restart();
		done_criteria = '0;
		m_fresh = '0;
		hwreset_req = 1'b1;
		pick_delays();
	endtask

	// raises criteria as steps of the current wave reach wait_done
	task automatic run_chain(input int gate, input int stuck, input int restart_at);
		int n;
		int fall_at;
		int err_at;
		bit finished;
		logic [NSTEP-1:0] prev_reset;
		n = 0;
		fall_at = -1;
		err_at = -1;
		finished = 0;
		prev_reset = step_reset;
		while (!finished && n < RUN_CAP) begin
			@(negedge hw);
			n++;
			hwreset_req = 1'b0;
			if (n == restart_at)
				begin_restart();
			for (int k = 0; k < NSTEP; k++) begin
				if (m_state[k] == S_WAIT && m_fresh[k] && k != stuck && !done_criteria[k]) begin
					if (delay[k] == 0)
						done_criteria[k] = 1'b1;
					else
						delay[k]--;
				end
			end
			if (gate > 0 && m_state[gate] == S_READY && m_fresh[gate])
				done_criteria[gate-1] = ($urandom_range(0, 3) != 0); // mostly high
			if (stuck >= 0) begin
				if (prev_reset[stuck] && !step_reset[stuck])
					fall_at = n;
				compare("step_reset after stuck step", step_reset >> (stuck + 1), '0);
				if (step_error[stuck] && err_at < 0) begin
					err_at = n;
					compare("timeout cycles", n - fall_at, TIMEOUT);
				end
				finished = (err_at >= 0) && (n >= err_at + 50);
			end else begin
				// done flags left from an earlier wave do not count
				finished = (&step_done) && (&m_fresh) && (n > restart_at);
			end
			prev_reset = step_reset;
		end
		if (!finished) begin
			errors++;
			$display("chain run did not finish within %0d cycles", RUN_CAP);
		end
	endtask

	task automatic send_cmd(input logic [36:0] cmd);
		i2c_cmd = cmd;
		@(negedge hw);
	endtask

	task automatic send_result(input logic [7:0] data);
		i2c_result_data = $urandom;
		i2c_result_data[7:0] = data;
		i2c_result_valid = 1'b1;
		@(negedge hw);
		i2c_result_valid = 1'b0;
		@(negedge hw);
	endtask

	task automatic report(input string name, input int errors_before);
		if (errors == errors_before) begin
			passed++;
			$display("test %s: ok", name);
		end else begin
			failed++;
			$display("test %s: %0d errors", name, errors - errors_before);
		end
	endtask

	initial begin
		int unsigned seed_init;
		int e0;
		int assert_fails;
		logic [7:0] id_bytes [10];
		logic [47:0] exp_mac;
		logic [31:0] exp_ip;
		seed_init = $urandom(32'h3a2fa8a9);
		poweronreset = 1'b1;
		hwreset_req = 1'b0;
		done_criteria = '0;
		i2c_cmd = '0;
		i2c_result_valid = 1'b0;
		i2c_result_data = '0;
		i2c_init_done = 1'b0;
		use_default_id = 1'b0;
		repeat (5) @(negedge hw);
		poweronreset = 1'b0;
		checks_on = 1;

		e0 = errors;
		pick_delays();
		run_chain(0, -1, -1);
		report("power-on sequence", e0);

		e0 = errors;
		begin_restart();
		run_chain($urandom_range(1, NSTEP - 1), -1, -1);
		report("readiness gating", e0);

		e0 = errors;
		begin_restart();
		run_chain(0, $urandom_range(0, NSTEP - 2), -1);
		report("timeout", e0);

		e0 = errors;
		begin_restart();
		run_chain(0, -1, 30 + $urandom_range(0, 150)); // second request mid-run
		compare("step_error", step_error, '0);
		report("restart", e0);

		e0 = errors;
		send_cmd({1'b1, 4'h2, 8'he8, 8'($urandom_range(0, 7)), 16'h0});
		send_cmd({1'b1, 4'h3, 8'h01, 8'ha0, 16'($urandom)});
		repeat (3) send_result($urandom); // wrong mux port
		send_cmd({1'b1, 4'h2, 8'he8, 8'd8, 16'h0});
		send_cmd({1'b1, 4'h2, 8'h00, 8'ha0, 16'($urandom)});
		send_result($urandom); // a write, not a read
		send_cmd({1'b1, 4'h3, 8'h01, 8'ha0, 16'($urandom)});
		for (int i = 0; i < 10; i++) begin
			id_bytes[i] = $urandom;
			send_result(id_bytes[i]);
		end
		i2c_init_done = 1'b1;
		send_result($urandom); // after init
		i2c_cmd = '0;
		for (int i = 0; i < 6; i++)
			exp_mac[47 - 8 * i -: 8] = id_bytes[i]; // first byte on top
		for (int i = 0; i < 4; i++)
			exp_ip[31 - 8 * i -: 8] = id_bytes[6 + i];
		begin_restart();
		run_chain(0, -1, -1);
		compare("mac", mac, exp_mac);
		compare("ip", ip, exp_ip);
		use_default_id = 1'b1;
		begin_restart();
		run_chain(0, -1, -1);
		compare("mac", mac, FACTORY_MAC);
		compare("ip", ip, FACTORY_IP);
		report("identity capture and load", e0);

		assert_fails = i_board_init_top.i_reset_chain.i_board_init_assert.fail_count;
		if (assert_fails != 0) begin
			errors += assert_fails;
			$display("%0d assertion failures during the run", assert_fails);
		end
		$display("tests passed %0d, failed %0d, checks %0d, errors %0d",
			passed, failed, checks, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule
